/* src/perip_pkg.sv */
package perip_pkg;

    ////////////////////
    // address map
    ////////////////////

    // dtcm window, 4 KiB of 32-bit words
    localparam logic [31:0] DTCM_BASE  = 32'h8010_0000;
    localparam int          DTCM_WORDS = 1024;
    localparam int          DTCM_AW    = 10;

    // read-only inputs
    localparam logic [31:0] SW0_ADDR = 32'h8020_0000;
    localparam logic [31:0] SW1_ADDR = 32'h8020_0004;
    localparam logic [31:0] KEY_ADDR = 32'h8020_0010;

    // read/write registers
    localparam logic [31:0] SEG_ADDR = 32'h8020_0020;
    localparam logic [31:0] LED_ADDR = 32'h8020_0040;
    localparam logic [31:0] CNT_ADDR = 32'h8020_0050;

    // value seen on any unmapped read
    localparam logic [31:0] READ_DEFAULT = 32'hDEAD_BEEF;

    ////////////////////
    // timing
    ////////////////////

    // one counter step per microsecond at 50 MHz
    localparam int CNT_DIV = 50;
    localparam int CNT_PW  = $clog2(CNT_DIV);

    // clocks per display phase
    localparam int SCAN_DIV = 1000;
    localparam int SCAN_PW  = $clog2(SCAN_DIV);

    // display scan phases, blanks sit between the two digits
    typedef enum logic [1:0] {
        PH_BLANK_A = 2'd0,
        PH_LO      = 2'd1,
        PH_BLANK_B = 2'd2,
        PH_HI      = 2'd3
    } seg_phase_t;

endpackage

/* src/perip_if.sv */
`timescale 1ns/1ps

interface perip_if;

    // write port, single-cycle strobe
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic        wen;
    // bit i enables byte i
    logic [3:0]  mask;

    // read port, data one cycle after the address
    logic [31:0] raddr;
    logic [31:0] rdata;

    // requester side
    modport cpu (
        output waddr, wdata, wen, mask, raddr,
        input  rdata
    );

    // target side
    modport dev (
        input  waddr, wdata, wen, mask, raddr,
        output rdata
    );

endinterface

/* src/dtcm_ram.sv */
`timescale 1ns/1ps

module dtcm_ram
    import perip_pkg::*;
(
    input  logic  clk,
    perip_if.dev  port
);

    logic [31:0]        mem [DTCM_WORDS];
    logic [DTCM_AW-1:0] wa;
    logic [DTCM_AW-1:0] ra;

    // bridge has already reduced addresses to word indices
    assign wa = port.waddr[DTCM_AW-1:0];
    assign ra = port.raddr[DTCM_AW-1:0];

    ////////////////////
    // byte-masked write
    ////////////////////

    always_ff @(posedge clk) begin
        if (port.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (port.mask[b]) begin
                    mem[wa][8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // synchronous read
    ////////////////////

    // same-word collision returns the word before the write
    always_ff @(posedge clk) begin
        port.rdata <= mem[ra];
    end

endmodule

/* src/perip_timer.sv */
`timescale 1ns/1ps

module perip_timer
    import perip_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cnt_load,
    input  logic [31:0] cnt_load_value,
    output logic [31:0] cnt_value,
    output logic        scan_tick
);

    logic [CNT_PW-1:0]  cnt_pre;
    logic [SCAN_PW-1:0] scan_pre;
    logic               cnt_wrap;

    assign cnt_wrap = (cnt_pre == CNT_PW'(CNT_DIV - 1));

    ////////////////////
    // cycle counter
    ////////////////////

    // a load wins over counting and restarts the prescaler
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_pre   <= '0;
            cnt_value <= '0;
        end else if (cnt_load) begin
            cnt_pre   <= '0;
            cnt_value <= cnt_load_value;
        end else if (cnt_wrap) begin
            cnt_pre   <= '0;
            cnt_value <= cnt_value + 32'd1;
        end else begin
            cnt_pre <= cnt_pre + 1'b1;
        end
    end

    ////////////////////
    // display scan tick
    ////////////////////

    // free running, not affected by counter loads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_pre <= '0;
        end else if (scan_tick) begin
            scan_pre <= '0;
        end else begin
            scan_pre <= scan_pre + 1'b1;
        end
    end

    // high for the last cycle of each phase
    assign scan_tick = (scan_pre == SCAN_PW'(SCAN_DIV - 1));

endmodule

/* src/seg_scan_fsm.sv */
`timescale 1ns/1ps

module seg_scan_fsm
    import perip_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       scan_tick,
    output seg_phase_t phase
);

    seg_phase_t state;
    seg_phase_t state_next;

    ////////////////////
    // next state
    ////////////////////

    // low digit, blank, high digit, blank, repeat
    always_comb begin
        state_next = state;
        if (scan_tick) begin
            case (state)
                PH_BLANK_A: begin
                    state_next = PH_LO;
                end
                PH_LO: begin
                    // blank before switching anodes
                    state_next = PH_BLANK_B;
                end
                PH_BLANK_B: begin
                    state_next = PH_HI;
                end
                PH_HI: begin
                    state_next = PH_BLANK_A;
                end
                default: begin
                    state_next = PH_BLANK_A;
                end
            endcase
        end
    end

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= PH_BLANK_A;
        end else begin
            state <= state_next;
        end
    end

    assign phase = state;

endmodule

/* src/seg_digit_mux.sv */
`timescale 1ns/1ps

module seg_digit_mux
    import perip_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  seg_phase_t  phase,
    input  logic [31:0] seg_value,
    output logic [39:0] seg_out
);

    logic [39:0] seg_next;
    logic [3:0]  nib;

    // hex to segments a..g, active high, bit 0 is a
    function automatic logic [6:0] hex7(input logic [3:0] h);
        case (h)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // group g shows nibble 2g on the low digit, 2g+1 on the high one
    always_comb begin
        seg_next = '0;
        nib      = '0;
        for (int g = 0; g < 4; g++) begin
            nib = (phase == PH_HI) ? seg_value[8*g+4 +: 4] : seg_value[8*g +: 4];
            if (phase == PH_LO || phase == PH_HI) begin
                seg_next[10*g +: 7] = hex7(nib);
                seg_next[10*g + 8]  = (phase == PH_LO);
                seg_next[10*g + 9]  = (phase == PH_HI);
            end
        end
    end

    // decimal points stay at zero through seg_next
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_out <= '0;
        end else begin
            seg_out <= seg_next;
        end
    end

endmodule

/* src/perip_bridge.sv */
`timescale 1ns/1ps

module perip_bridge
    import perip_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [63:0]  sw_in,
    input  logic [7:0]   key_in,
    input  logic [31:0]  cnt_value,
    perip_if.dev         bus,
    perip_if.cpu         ram,
    output logic         cnt_load,
    output logic [31:0]  cnt_load_value,
    output logic [31:0]  seg_value,
    output logic [31:0]  led_out
);

    logic        dtcm_wsel;
    logic        dtcm_rsel;
    logic        rd_dtcm_q;
    logic [31:0] rd_mux_q;

    ////////////////////
    // address decode
    ////////////////////

    // window is aligned to its size, so the upper bits decide
    assign dtcm_wsel = (bus.waddr[31:DTCM_AW+2] == DTCM_BASE[31:DTCM_AW+2]);
    assign dtcm_rsel = (bus.raddr[31:DTCM_AW+2] == DTCM_BASE[31:DTCM_AW+2]);

    // dtcm sees word indices only
    assign ram.waddr = {{(32-DTCM_AW){1'b0}}, bus.waddr[DTCM_AW+1:2]};
    assign ram.raddr = {{(32-DTCM_AW){1'b0}}, bus.raddr[DTCM_AW+1:2]};
    assign ram.wdata = bus.wdata;
    assign ram.mask  = bus.mask;
    assign ram.wen   = bus.wen & dtcm_wsel;

    // counter load goes straight to the timer
    assign cnt_load       = bus.wen && (bus.waddr == CNT_ADDR);
    assign cnt_load_value = bus.wdata;

    ////////////////////
    // write side
    ////////////////////

    // full-word registers, byte mask only matters for dtcm
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_out   <= '0;
            seg_value <= '0;
        end else if (bus.wen) begin
            if (bus.waddr == LED_ADDR) begin
                led_out <= bus.wdata;
            end
            if (bus.waddr == SEG_ADDR) begin
                seg_value <= bus.wdata;
            end
        end
    end

    ////////////////////
    // read side
    ////////////////////

    // remember which source answers next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_dtcm_q <= 1'b0;
        end else begin
            rd_dtcm_q <= dtcm_rsel;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_mux_q <= '0;
        end else begin
            case (bus.raddr)
                SW0_ADDR: rd_mux_q <= sw_in[31:0];
                SW1_ADDR: rd_mux_q <= sw_in[63:32];
                KEY_ADDR: rd_mux_q <= {24'd0, key_in};
                SEG_ADDR: rd_mux_q <= seg_value;
                LED_ADDR: rd_mux_q <= led_out;
                CNT_ADDR: rd_mux_q <= cnt_value;
                default:  rd_mux_q <= READ_DEFAULT;
            endcase
        end
    end

    // ram output is already registered inside dtcm_ram
    assign bus.rdata = rd_dtcm_q ? ram.rdata : rd_mux_q;

endmodule

/* src/perip_top.sv */
`timescale 1ns/1ps

module perip_top
    import perip_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] perip_waddr,
    input  logic [31:0] perip_wdata,
    input  logic        perip_wen,
    input  logic [3:0]  perip_mask,
    input  logic [31:0] perip_raddr,
    input  logic [63:0] sw_in,
    input  logic [7:0]  key_in,
    output logic [31:0] perip_rdata,
    output logic [39:0] seg_out,
    output logic [31:0] led_out
);

    logic        cnt_load;
    logic [31:0] cnt_load_value;
    logic [31:0] cnt_value;
    logic [31:0] seg_value;
    logic        scan_tick;
    seg_phase_t  phase;

    perip_if bus_if ();
    perip_if ram_if ();

    ////////////////////
    // core data port
    ////////////////////

    assign bus_if.waddr = perip_waddr;
    assign bus_if.wdata = perip_wdata;
    assign bus_if.wen   = perip_wen;
    assign bus_if.mask  = perip_mask;
    assign bus_if.raddr = perip_raddr;
    assign perip_rdata  = bus_if.rdata;

    ////////////////////
    // blocks
    ////////////////////

    perip_bridge u_perip_bridge (
        .clk            (clk),
        .rst            (rst),
        .sw_in          (sw_in),
        .key_in         (key_in),
        .cnt_value      (cnt_value),
        .bus            (bus_if.dev),
        .ram            (ram_if.cpu),
        .cnt_load       (cnt_load),
        .cnt_load_value (cnt_load_value),
        .seg_value      (seg_value),
        .led_out        (led_out)
    );

    dtcm_ram u_dtcm_ram (
        .clk  (clk),
        .port (ram_if.dev)
    );

    perip_timer u_perip_timer (
        .clk            (clk),
        .rst            (rst),
        .cnt_load       (cnt_load),
        .cnt_load_value (cnt_load_value),
        .cnt_value      (cnt_value),
        .scan_tick      (scan_tick)
    );

    // display path
    seg_scan_fsm u_seg_scan_fsm (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .phase     (phase)
    );

    seg_digit_mux u_seg_digit_mux (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .seg_value (seg_value),
        .seg_out   (seg_out)
    );

endmodule

/* test/perip_tb.sv */
`timescale 1ns/1ps

module perip_tb
    import perip_pkg::*;
;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] exp;
    } row_t;

    // segments a..g per hex digit with digit 0 in the low bits
    localparam logic [111:0] HEX_SEG = {
        7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
        7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
    };

    logic        clk;
    logic        rst;
    logic [31:0] perip_waddr;
    logic [31:0] perip_wdata;
    logic        perip_wen;
    logic [3:0]  perip_mask;
    logic [31:0] perip_raddr;
    logic [63:0] sw_in;
    logic [7:0]  key_in;
    logic [31:0] perip_rdata;
    logic [39:0] seg_out;
    logic [31:0] led_out;

    row_t        rows[$];
    logic [31:0] model [DTCM_WORDS];
    int          errors;
    int          test_err0;
    int          tests_run;
    int          tests_failed;

    perip_top u_perip_top (
        .clk         (clk),
        .rst         (rst),
        .perip_waddr (perip_waddr),
        .perip_wdata (perip_wdata),
        .perip_wen   (perip_wen),
        .perip_mask  (perip_mask),
        .perip_raddr (perip_raddr),
        .sw_in       (sw_in),
        .key_in      (key_in),
        .perip_rdata (perip_rdata),
        .seg_out     (seg_out),
        .led_out     (led_out)
    );

    always #2 clk = ~clk;

    ////////////////////
    // bus helpers
    ////////////////////

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        perip_waddr = addr;
        perip_wdata = data;
        perip_mask  = mask;
        perip_wen   = 1'b1;
        step();
        perip_wen   = 1'b0;
    endtask

    // rdata is valid during the cycle after the address
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        perip_raddr = addr;
        step();
        data = perip_rdata;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  mask);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask, input logic [31:0] exp);
        rows.push_back(row_t'{wr, addr, data, mask, exp});
    endtask

    // write one dtcm word and read it back
    task automatic dtcm_row(input int word, input logic [31:0] data, input logic [3:0] mask);
        logic [31:0] addr;
        addr = DTCM_BASE + 32'(word * 4);
        model[word] = merge_bytes(model[word], data, mask);
        add_row(1'b1, addr, data, mask, 32'h0);
        add_row(1'b0, addr, 32'h0, 4'h0, model[word]);
    endtask

    task automatic run_rows();
        logic [31:0] got;
        foreach (rows[i]) begin
            if (rows[i].wr) begin
                bus_write(rows[i].addr, rows[i].data, rows[i].mask);
            end else begin
                bus_read(rows[i].addr, got);
                check("perip_rdata", got, rows[i].exp);
            end
        end
        rows.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err0);
        end else begin
            $display("test %s: passed", name);
        end
        test_err0 = errors;
    endtask

    ////////////////////
    // counter and display
    ////////////////////

    // count may be one ahead depending on the sampling edge
    task automatic counter_test();
        int          ks[6] = '{0, 1, 49, 50, 120, 260};
        logic [31:0] v;
        logic [31:0] got;
        logic [31:0] exp;
        foreach (ks[i]) begin
            v = $urandom;
            bus_write(CNT_ADDR, v, 4'h3);
            repeat (ks[i]) step();
            bus_read(CNT_ADDR, got);
            exp = v + ks[i] / CNT_DIV;
            if (got == exp + 1) begin
                exp = exp + 1;
            end
            check("perip_rdata", got, exp);
        end
    endtask

    task automatic display_test();
        logic [31:0] v;
        logic [3:0]  seen_lo;
        logic [3:0]  seen_hi;
        logic [9:0]  grp;
        int          cyc;
        v       = $urandom;
        seen_lo = '0;
        seen_hi = '0;
        cyc     = 0;
        bus_write(SEG_ADDR, v, 4'hF);
        // one cycle for the output register
        step();
        // two full scan periods or the first mismatch
        while (cyc < 8 * SCAN_DIV && errors == test_err0) begin
            for (int g = 0; g < 4; g++) begin
                grp = seg_out[10*g +: 10];
                check("seg_out dp", grp[7], 1'b0);
                if (grp[8] && grp[9]) begin
                    $display("group %0d drives both anodes at once", g);
                    errors++;
                end else if (grp[8]) begin
                    check("seg_out segments", grp[6:0], HEX_SEG[7*v[8*g +: 4] +: 7]);
                    seen_lo[g] = 1'b1;
                end else if (grp[9]) begin
                    check("seg_out segments", grp[6:0], HEX_SEG[7*v[8*g+4 +: 4] +: 7]);
                    seen_hi[g] = 1'b1;
                end else begin
                    // blank phase keeps every segment dark
                    check("seg_out segments", grp[6:0], 7'h00);
                end
            end
            step();
            cyc++;
        end
        if (errors == test_err0 && (seen_lo != 4'hF || seen_hi != 4'hF)) begin
            $display("timeout: not every digit was shown within two scan periods");
            errors++;
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [31:0] v;
        void'($urandom(56));
        clk          = 1'b0;
        rst          = 1'b1;
        perip_waddr  = '0;
        perip_wdata  = '0;
        perip_wen    = 1'b0;
        perip_mask   = '0;
        perip_raddr  = '0;
        sw_in        = '0;
        key_in       = '0;
        errors       = 0;
        test_err0    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values and then full-word writes regardless of mask
        check("perip_rdata", perip_rdata, 32'h0);
        check("led_out", led_out, 32'h0);
        check("seg_out", seg_out, 40'h0);
        add_row(1'b0, LED_ADDR, 32'h0, 4'h0, 32'h0);
        add_row(1'b0, SEG_ADDR, 32'h0, 4'h0, 32'h0);
        add_row(1'b0, CNT_ADDR, 32'h0, 4'h0, 32'h0);
        v = $urandom;
        add_row(1'b1, LED_ADDR, v, 4'h1, 32'h0);
        add_row(1'b0, LED_ADDR, 32'h0, 4'h0, v);
        v = $urandom;
        add_row(1'b1, SEG_ADDR, v, 4'h0, 32'h0);
        add_row(1'b0, SEG_ADDR, 32'h0, 4'h0, v);
        run_rows();
        v = $urandom;
        bus_write(LED_ADDR, v, 4'h0);
        check("led_out", led_out, v);
        end_test("registers");

        dtcm_row(0, $urandom, 4'hF);
        dtcm_row(DTCM_WORDS - 1, $urandom, 4'hF);
        dtcm_row(DTCM_WORDS / 2, $urandom, 4'hF);
        dtcm_row(0, $urandom, 4'b0101);
        dtcm_row(DTCM_WORDS - 1, $urandom, 4'b1000);
        dtcm_row(DTCM_WORDS / 2, $urandom, 4'b0110);
        // first word past the window
        add_row(1'b1, DTCM_BASE + 32'h1000, $urandom, 4'hF, 32'h0);
        add_row(1'b0, DTCM_BASE, 32'h0, 4'h0, model[0]);
        add_row(1'b0, DTCM_BASE + 32'h1000, 32'h0, 4'h0, READ_DEFAULT);
        run_rows();
        end_test("dtcm");

        sw_in  = {$urandom, $urandom};
        key_in = 8'($urandom);
        add_row(1'b0, SW0_ADDR, 32'h0, 4'h0, sw_in[31:0]);
        add_row(1'b0, SW1_ADDR, 32'h0, 4'h0, sw_in[63:32]);
        add_row(1'b0, KEY_ADDR, 32'h0, 4'h0, {24'h0, key_in});
        add_row(1'b0, 32'h8020_0008, 32'h0, 4'h0, READ_DEFAULT);
        add_row(1'b0, 32'h0000_0000, 32'h0, 4'h0, READ_DEFAULT);
        run_rows();
        end_test("inputs");

        counter_test();
        end_test("counter");

        display_test();
        end_test("display");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
src/perip_pkg.sv
src/perip_if.sv
src/dtcm_ram.sv
src/perip_timer.sv
src/seg_scan_fsm.sv
src/seg_digit_mux.sv
src/perip_bridge.sv
src/perip_top.sv
test/perip_tb.sv

/* Bender.yml */
package:
  name: perip

sources:
  - src/perip_pkg.sv
  - src/perip_if.sv
  - src/dtcm_ram.sv
  - src/perip_timer.sv
  - src/seg_scan_fsm.sv
  - src/seg_digit_mux.sv
  - src/perip_bridge.sv
  - src/perip_top.sv
  - target: test
    files:
      - test/perip_tb.sv
